// ==== logic/sys_master_consts.svh ====
// Bus widths and reset timing constants, included by the package and by the bridge RTL
`ifndef SYS_MASTER_CONSTS_SVH
`define SYS_MASTER_CONSTS_SVH

// Data widths of the two buses
`define SM_HOST_DW    64
`define SM_SOC_DW     32

// Shared address width
`define SM_AW         32

// Byte selects, one per data byte
`define SM_HOST_SELW  8
`define SM_SOC_SELW   4

`define SM_RST_HOLD   16    // SoC reset hold after lock, in cycles

`define SM_HALF_OFS   4     // Byte offset of the upper SoC word

`endif

// ==== logic/sys_master_pkg.sv ====
// Request and data types of the host and SoC Wishbone buses, imported by the bridge RTL
`include "sys_master_consts.svh"

package sys_master_pkg;

    ////////////////////
    // Data words
    ////////////////////

    typedef logic [`SM_HOST_DW-1:0] host_dat_t;    // Host side, 64 bit
    typedef logic [`SM_SOC_DW-1:0]  soc_dat_t;     // SoC side, 32 bit

    ////////////////////
    // Requests
    ////////////////////

    // Host access, 105 bits
    typedef struct packed {
        logic                     we;
        logic [`SM_AW-1:0]        adr;
        host_dat_t                dat;
        logic [`SM_HOST_SELW-1:0] sel;
    } host_req_t;

    // SoC access, 69 bits
    typedef struct packed {
        logic                    we;
        logic [`SM_AW-1:0]       adr;
        soc_dat_t                dat;
        logic [`SM_SOC_SELW-1:0] sel;
    } soc_req_t;

endpackage : sys_master_pkg

// ==== logic/rst_gen.sv ====
// SoC reset generator that holds reset low for a fixed count once the PLL has locked
`timescale 1ns/1ps

`include "sys_master_consts.svh"

module rst_gen (
    input  logic sys_clock_i,
    input  logic rst_n_i,
    input  logic locked_i,
    output logic soc_rstn_o
);

    localparam int unsigned CNT_W = $clog2(`SM_RST_HOLD + 1);

    logic             start_ok;     // System out of reset and clock stable
    logic [CNT_W-1:0] hold_cnt_q;

    assign start_ok = rst_n_i && locked_i;

    ////////////////////
    // Hold counter
    ////////////////////

    always_ff @(posedge sys_clock_i) begin
        if (!start_ok) begin
            hold_cnt_q <= '0;
            soc_rstn_o <= 1'b0;
        end else begin
            if (hold_cnt_q != CNT_W'(`SM_RST_HOLD)) begin
                hold_cnt_q <= hold_cnt_q + 1'b1;    // Saturates at the hold length
            end
            soc_rstn_o <= (hold_cnt_q == CNT_W'(`SM_RST_HOLD));
        end
    end

    // Losing lock must pull the SoC into reset on the very next cycle
    a_lock_drop: assert property (
        @(posedge sys_clock_i) !locked_i |=> !soc_rstn_o
    );

endmodule : rst_gen

// ==== logic/wb_stage.sv ====
// One-entry Wishbone classic register slice, placed on either side of the width converter
`timescale 1ns/1ps

module wb_stage #(
    parameter type req_t = sys_master_pkg::soc_req_t,
    parameter type dat_t = sys_master_pkg::soc_dat_t
) (
    input  logic sys_clock_i,
    input  logic rst_n_i,
    // Upstream slave side
    input  logic up_cyc_i,
    input  logic up_stb_i,
    input  req_t up_req_i,
    output logic up_ack_o,
    output dat_t up_dat_o,
    // Downstream master side
    output logic dn_cyc_o,
    output logic dn_stb_o,
    output req_t dn_req_o,
    input  logic dn_ack_i,
    input  dat_t dn_dat_i
);

    typedef enum logic [1:0] {
        ST_IDLE,    // Waiting for an upstream strobe
        ST_BUSY,    // Access presented downstream
        ST_RESP     // Upstream ack cycle
    } state_e;

    state_e state_q;
    req_t   req_q;
    dat_t   dat_q;

    ////////////////////
    // Control
    ////////////////////

    always_ff @(posedge sys_clock_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: if (up_cyc_i && up_stb_i) state_q <= ST_BUSY;
                ST_BUSY: if (dn_ack_i) state_q <= ST_RESP;
                default: state_q <= ST_IDLE;    // One ack, then free again
            endcase
        end
    end

    // Payload registers
    always_ff @(posedge sys_clock_i) begin
        if (state_q == ST_IDLE && up_cyc_i && up_stb_i) begin
            req_q <= up_req_i;
        end
        if (state_q == ST_BUSY && dn_ack_i) begin
            dat_q <= dn_dat_i;
        end
    end

    assign dn_cyc_o = (state_q == ST_BUSY);
    assign dn_stb_o = (state_q == ST_BUSY);
    assign dn_req_o = req_q;
    assign up_ack_o = (state_q == ST_RESP);
    assign up_dat_o = dat_q;

    a_ack_single: assert property (
        @(posedge sys_clock_i) disable iff (!rst_n_i) up_ack_o |=> !up_ack_o
    );

    // A stalled downstream access keeps its request untouched
    a_req_stable: assert property (
        @(posedge sys_clock_i) disable iff (!rst_n_i)
        dn_stb_o && !dn_ack_i |=> dn_stb_o && $stable(dn_req_o)
    );

endmodule : wb_stage

// ==== logic/wb_dwidth_down.sv ====
// Wishbone 64 to 32 bit down-converter, one host access becomes up to two SoC accesses
`timescale 1ns/1ps

`include "sys_master_consts.svh"

module wb_dwidth_down (
    input  logic                      sys_clock_i,
    input  logic                      rst_n_i,
    // Host side, 64 bit
    input  logic                      host_cyc_i,
    input  logic                      host_stb_i,
    input  sys_master_pkg::host_req_t host_req_i,
    output logic                      host_ack_o,
    output sys_master_pkg::host_dat_t host_dat_o,
    // SoC side, 32 bit
    output logic                      soc_cyc_o,
    output logic                      soc_stb_o,
    output sys_master_pkg::soc_req_t  soc_req_o,
    input  logic                      soc_ack_i,
    input  sys_master_pkg::soc_dat_t  soc_dat_i
);

    import sys_master_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LO,      // Lower word at the aligned address
        ST_HI,      // Upper word at the aligned address plus 4
        ST_ACK
    } state_e;

    state_e            state_q;
    host_req_t         req_q;
    host_dat_t         rdat_q;
    logic [`SM_AW-1:0] base_adr;
    logic              lo_sel;
    logic              hi_sel;
    logic              new_sel_lo;
    logic              new_sel_hi;

    // 8-byte aligned host address
    assign base_adr = {req_q.adr[`SM_AW-1:3], 3'b000};

    assign lo_sel = |req_q.sel[`SM_SOC_SELW-1:0];
    assign hi_sel = |req_q.sel[`SM_HOST_SELW-1:`SM_SOC_SELW];

    // Same test on the incoming request, used at capture
    assign new_sel_lo = |host_req_i.sel[`SM_SOC_SELW-1:0];
    assign new_sel_hi = |host_req_i.sel[`SM_HOST_SELW-1:`SM_SOC_SELW];

    ////////////////////
    // Sequencer
    ////////////////////

    always_ff @(posedge sys_clock_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (host_cyc_i && host_stb_i) begin
                        if (new_sel_lo)      state_q <= ST_LO;
                        else if (new_sel_hi) state_q <= ST_HI;
                        else                 state_q <= ST_ACK;    // Nothing selected
                    end
                end
                ST_LO: begin
                    if (soc_ack_i) state_q <= hi_sel ? ST_HI : ST_ACK;
                end
                ST_HI: begin
                    if (soc_ack_i) state_q <= ST_ACK;
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Request capture and read data assembly
    always_ff @(posedge sys_clock_i) begin
        if (state_q == ST_IDLE && host_cyc_i && host_stb_i) begin
            req_q  <= host_req_i;
            rdat_q <= '0;    // Halves not accessed read as zero
        end
        if (state_q == ST_LO && soc_ack_i && !req_q.we) begin
            rdat_q[`SM_SOC_DW-1:0] <= soc_dat_i;
        end
        if (state_q == ST_HI && soc_ack_i && !req_q.we) begin
            rdat_q[`SM_HOST_DW-1:`SM_SOC_DW] <= soc_dat_i;
        end
    end

    ////////////////////
    // SoC request
    ////////////////////

    always_comb begin
        soc_req_o.we  = req_q.we;
        soc_req_o.adr = base_adr;
        soc_req_o.dat = req_q.dat[`SM_SOC_DW-1:0];
        soc_req_o.sel = req_q.sel[`SM_SOC_SELW-1:0];
        if (state_q == ST_HI) begin
            soc_req_o.adr = base_adr + `SM_AW'(`SM_HALF_OFS);
            soc_req_o.dat = req_q.dat[`SM_HOST_DW-1:`SM_SOC_DW];
            soc_req_o.sel = req_q.sel[`SM_HOST_SELW-1:`SM_SOC_SELW];
        end
    end

    assign soc_stb_o  = (state_q == ST_LO) || (state_q == ST_HI);
    assign soc_cyc_o  = soc_stb_o;
    assign host_ack_o = (state_q == ST_ACK);    // Follows the last SoC ack
    assign host_dat_o = rdat_q;

endmodule : wb_dwidth_down

// ==== logic/sys_master_top.sv ====
// Host to SoC bus master bridge top, reset generation plus 64 to 32 bit Wishbone path
`timescale 1ns/1ps

module sys_master_top (
    input  logic                      sys_clock_i,
    input  logic                      rst_n_i,
    input  logic                      locked_i,
    output logic                      soc_rstn_o,
    // Host Wishbone slave port
    input  logic                      host_cyc_i,
    input  logic                      host_stb_i,
    input  sys_master_pkg::host_req_t host_req_i,
    output logic                      host_ack_o,
    output sys_master_pkg::host_dat_t host_dat_o,
    // SoC Wishbone master port
    output logic                      soc_cyc_o,
    output logic                      soc_stb_o,
    output sys_master_pkg::soc_req_t  soc_req_o,
    input  logic                      soc_ack_i,
    input  sys_master_pkg::soc_dat_t  soc_dat_i
);

    import sys_master_pkg::*;

    logic      soc_rstn;

    // Host stage to converter
    logic      hs_cyc;
    logic      hs_stb;
    host_req_t hs_req;
    logic      hs_ack;
    host_dat_t hs_dat;

    // Converter to SoC stage
    logic      cv_cyc;
    logic      cv_stb;
    soc_req_t  cv_req;
    logic      cv_ack;
    soc_dat_t  cv_dat;

    ////////////////////
    // Reset
    ////////////////////

    rst_gen rst_gen_u (
        .sys_clock_i ( sys_clock_i ),
        .rst_n_i     ( rst_n_i     ),
        .locked_i    ( locked_i    ),
        .soc_rstn_o  ( soc_rstn    )
    );

    assign soc_rstn_o = soc_rstn;

    ////////////////////
    // Bus path
    ////////////////////

    wb_stage #(
        .req_t ( host_req_t ),
        .dat_t ( host_dat_t )
    ) host_stage (
        .sys_clock_i ( sys_clock_i ),
        .rst_n_i     ( soc_rstn    ),
        .up_cyc_i    ( host_cyc_i  ),
        .up_stb_i    ( host_stb_i  ),
        .up_req_i    ( host_req_i  ),
        .up_ack_o    ( host_ack_o  ),
        .up_dat_o    ( host_dat_o  ),
        .dn_cyc_o    ( hs_cyc      ),
        .dn_stb_o    ( hs_stb      ),
        .dn_req_o    ( hs_req      ),
        .dn_ack_i    ( hs_ack      ),
        .dn_dat_i    ( hs_dat      )
    );

    wb_dwidth_down dwidth_down_u (
        .sys_clock_i ( sys_clock_i ),
        .rst_n_i     ( soc_rstn    ),
        .host_cyc_i  ( hs_cyc      ),
        .host_stb_i  ( hs_stb      ),
        .host_req_i  ( hs_req      ),
        .host_ack_o  ( hs_ack      ),
        .host_dat_o  ( hs_dat      ),
        .soc_cyc_o   ( cv_cyc      ),
        .soc_stb_o   ( cv_stb      ),
        .soc_req_o   ( cv_req      ),
        .soc_ack_i   ( cv_ack      ),
        .soc_dat_i   ( cv_dat      )
    );

    wb_stage #(
        .req_t ( soc_req_t ),
        .dat_t ( soc_dat_t )
    ) soc_stage (
        .sys_clock_i ( sys_clock_i ),
        .rst_n_i     ( soc_rstn    ),
        .up_cyc_i    ( cv_cyc      ),
        .up_stb_i    ( cv_stb      ),
        .up_req_i    ( cv_req      ),
        .up_ack_o    ( cv_ack      ),
        .up_dat_o    ( cv_dat      ),
        .dn_cyc_o    ( soc_cyc_o   ),
        .dn_stb_o    ( soc_stb_o   ),
        .dn_req_o    ( soc_req_o   ),
        .dn_ack_i    ( soc_ack_i   ),
        .dn_dat_i    ( soc_dat_i   )
    );

endmodule : sys_master_top

// ==== test/tb_clock_gen.sv ====
// Testbench clock and system reset source, 20 ns period with reset held for the first cycles
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int RST_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;    // 50 MHz
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule : tb_clock_gen

// ==== test/tb_soc_mem.sv ====
// 32-bit Wishbone memory model for the SoC port, wait states taken from address bits [3:2]
`timescale 1ns/1ps

module tb_soc_mem (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     cyc_i,
    input  logic                     stb_i,
    input  sys_master_pkg::soc_req_t req_i,
    output logic                     ack_o,
    output sys_master_pkg::soc_dat_t dat_o,
    output int unsigned              acc_cnt_o
);

    import sys_master_pkg::*;

    localparam int WORDS = 128;    // 64 host words

    soc_dat_t    mem_q [WORDS];
    logic [1:0]  wait_q = 2'd0;
    logic        ack_q  = 1'b0;
    soc_dat_t    dat_q  = '0;
    int unsigned cnt_q  = 0;
    logic [6:0]  word_idx;

    assign word_idx  = req_i.adr[8:2];
    assign ack_o     = ack_q;
    assign dat_o     = dat_q;
    assign acc_cnt_o = cnt_q;

    // Fill pattern built from the word address
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem_q[i] = 32'h5A00_0000 | (32'(i) * 32'h0001_0101);
        end
    end

    always @(posedge clk_i) begin
        ack_q <= 1'b0;    // Single cycle ack
        if (!rst_n_i) begin
            wait_q <= '0;
        end else if (cyc_i && stb_i && !ack_q) begin
            if (wait_q == req_i.adr[3:2]) begin
                wait_q <= '0;
                ack_q  <= 1'b1;
                cnt_q  <= cnt_q + 1;
                if (req_i.we) begin
                    for (int b = 0; b < 4; b++) begin
                        if (req_i.sel[b]) mem_q[word_idx][8*b +: 8] <= req_i.dat[8*b +: 8];
                    end
                end else begin
                    dat_q <= mem_q[word_idx];
                end
            end else begin
                wait_q <= wait_q + 2'd1;
            end
        end
    end

endmodule : tb_soc_mem

// ==== test/tb_sys_master.sv ====
// Testbench top that runs random host accesses on the bridge against a shadow memory
`timescale 1ns/1ps

`include "sys_master_consts.svh"

module tb_sys_master;

    import sys_master_pkg::*;

    localparam int N_ACCESS    = 200;
    localparam int CYCLE_LIMIT = N_ACCESS * 40 + 200;

    logic        sys_clock;
    logic        rst_n;
    logic        locked;
    logic        soc_rstn;
    logic        host_cyc;
    logic        host_stb;
    host_req_t   host_req;
    logic        host_ack;
    host_dat_t   host_dat;
    logic        soc_cyc;
    logic        soc_stb;
    soc_req_t    soc_req;
    logic        soc_ack;
    soc_dat_t    soc_dat;
    int unsigned soc_acc_cnt;

    host_dat_t   shadow [64];    // One host word per entry
    logic [31:0] lcg_state   = 32'd49;
    int          cycle_cnt   = 0;
    int          reset_waits = 0;    // Cycles a request sat in front of a held reset

    tb_clock_gen clk_gen_u (
        .clk_o   ( sys_clock ),
        .rst_n_o ( rst_n     )
    );

    sys_master_top DUT (
        .sys_clock_i ( sys_clock ),
        .rst_n_i     ( rst_n     ),
        .locked_i    ( locked    ),
        .soc_rstn_o  ( soc_rstn  ),
        .host_cyc_i  ( host_cyc  ),
        .host_stb_i  ( host_stb  ),
        .host_req_i  ( host_req  ),
        .host_ack_o  ( host_ack  ),
        .host_dat_o  ( host_dat  ),
        .soc_cyc_o   ( soc_cyc   ),
        .soc_stb_o   ( soc_stb   ),
        .soc_req_o   ( soc_req   ),
        .soc_ack_i   ( soc_ack   ),
        .soc_dat_i   ( soc_dat   )
    );

    tb_soc_mem mem_u (
        .clk_i     ( sys_clock   ),
        .rst_n_i   ( soc_rstn    ),
        .cyc_i     ( soc_cyc     ),
        .stb_i     ( soc_stb     ),
        .req_i     ( soc_req     ),
        .ack_o     ( soc_ack     ),
        .dat_o     ( soc_dat     ),
        .acc_cnt_o ( soc_acc_cnt )
    );

    ////////////////////
    // Helpers
    ////////////////////

    function automatic logic [31:0] init_word(input int unsigned i);
        return 32'h5A00_0000 | (i * 32'h0001_0101);    // Same fill as the memory model
    endfunction

    function automatic logic [15:0] rand16();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];    // Upper bits since the low ones cycle too fast
    endfunction

    function automatic int unsigned half_count(input logic [7:0] sel);
        return 32'(sel[3:0] != 4'h0) + 32'(sel[7:4] != 4'h0);
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    // One Wishbone classic access on the host port
    task automatic host_access(input logic we, input logic [31:0] adr,
                               input host_dat_t dat, input logic [7:0] sel);
        int unsigned cnt_before;
        int unsigned idx;
        host_dat_t   exp_dat;
        cnt_before = soc_acc_cnt;
        idx        = 32'(adr[8:3]);
        exp_dat    = '0;    // Unselected halves read as zero
        if (sel[3:0] != 4'h0) exp_dat[31:0] = shadow[idx][31:0];
        if (sel[7:4] != 4'h0) exp_dat[63:32] = shadow[idx][63:32];
        @(posedge sys_clock);
        host_cyc <= 1'b1;
        host_stb <= 1'b1;
        host_req <= '{we: we, adr: adr, dat: dat, sel: sel};
        do begin
            @(negedge sys_clock);
            if (!soc_rstn) begin
                reset_waits++;
                check_value("host_ack_o", 64'(host_ack), 64'd0);
                check_value("soc_cyc_o", 64'(soc_cyc), 64'd0);
                check_value("soc_stb_o", 64'(soc_stb), 64'd0);
            end
        end while (!host_ack);
        if (!we) check_value("host_dat_o", host_dat, exp_dat);
        check_value("soc_access_count", 64'(soc_acc_cnt - cnt_before), 64'(half_count(sel)));
        if (we) begin
            for (int b = 0; b < 8; b++) begin
                if (sel[b]) shadow[idx][8*b +: 8] = dat[8*b +: 8];
            end
        end
        @(posedge sys_clock);
        host_cyc <= 1'b0;
        host_stb <= 1'b0;
    endtask

    task automatic random_accesses(input int count, input logic full_sel);
        logic [15:0] r;
        logic [7:0]  sel;
        host_dat_t   dat;
        for (int n = 0; n < count; n++) begin
            r   = rand16();
            dat = {rand16(), rand16(), rand16(), rand16()};
            sel = 8'hFF;
            if (!full_sel) begin
                sel = 8'(rand16());
                if (r[10:9] == 2'd0) sel = 8'h00;
                if (r[10:9] == 2'd1) sel[7:4] = 4'h0;    // Low half only
                if (r[10:9] == 2'd2) sel[3:0] = 4'h0;
            end
            // 64 entries with the low address bits left unaligned
            host_access(r[15], {23'd0, r[5:0], r[8:6]}, dat, sel);
        end
    endtask

    task automatic reset_hold_test();
        int hold_cycles;
        do @(negedge sys_clock); while (!rst_n);
        check_value("soc_rstn_o", 64'(soc_rstn), 64'd0);
        @(posedge sys_clock);
        locked <= 1'b1;
        @(posedge sys_clock);    // First edge with rst_n and lock both high
        hold_cycles = 0;
        @(negedge sys_clock);
        while (!soc_rstn) begin
            @(posedge sys_clock);
            hold_cycles++;
            @(negedge sys_clock);
        end
        check_value("soc_rstn_o hold cycles", 64'(hold_cycles), 64'(`SM_RST_HOLD));
        @(posedge sys_clock);
        locked <= 1'b0;
        @(negedge sys_clock);
        check_value("soc_rstn_o", 64'(soc_rstn), 64'd1);    // That edge still saw lock
        @(negedge sys_clock);
        check_value("soc_rstn_o", 64'(soc_rstn), 64'd0);
    endtask

    ////////////////////
    // Run
    ////////////////////

    always @(posedge sys_clock) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SOME TESTS FAILED");
            $fatal(1, "Simulation timeout");
        end
    end

    initial begin
        locked   = 1'b0;
        host_cyc = 1'b0;
        host_stb = 1'b0;
        host_req = '0;
        for (int i = 0; i < 64; i++) begin
            shadow[i] = {init_word(32'(2 * i + 1)), init_word(32'(2 * i))};
        end

        reset_hold_test();

        // Request raised while the SoC reset is held again
        @(posedge sys_clock);
        locked <= 1'b1;
        host_access(1'b0, 32'h0000_001C, '0, 8'hFF);
        check_value("reset_wait_cycles", 64'(reset_waits > 0), 64'd1);

        random_accesses(N_ACCESS / 2, 1'b1);    // Full words
        random_accesses(N_ACCESS / 2, 1'b0);    // Partial and empty selects

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule : tb_sys_master

// ==== build.f ====
+incdir+logic
logic/sys_master_pkg.sv
logic/rst_gen.sv
logic/wb_stage.sv
logic/wb_dwidth_down.sv
logic/sys_master_top.sv
test/tb_clock_gen.sv
test/tb_soc_mem.sv
test/tb_sys_master.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -j 0 \
    -f build.f \
    --top-module tb_sys_master \
    -o sim_tb_sys_master

out=$(./obj_dir/sim_tb_sys_master 2>&1 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "ALL TESTS PASSED"; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
